// File: Makefile
TOP = cpuTb

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: filelist.f
+incdir+source
source/cpuPkg.sv
source/memAccess_if.sv
source/registerFile.sv
source/executeUnit.sv
source/memoryPort.sv
source/sequencer.sv
source/cpuTop.sv
testbench/cpuTop_properties.sv
testbench/cpuTb.sv

// File: source/cpuCore_config.svh
`ifndef CPU_CORE_CONFIG_SVH
`define CPU_CORE_CONFIG_SVH

// Width of data words and byte addresses
`define DATA_WIDTH 32

// General register file size
`define REG_COUNT 16
`define REG_INDEX_WIDTH 4

// Bytes moved per push or pop
`define STACK_STEP 4

// First instruction address
`define RESET_ADDRESS 32'h0000_0000

`endif

// File: source/cpuPkg.sv
`include "cpuCore_config.svh"

package cpuPkg;

  typedef logic [`DATA_WIDTH-1:0] word_t;
  typedef logic [`REG_INDEX_WIDTH-1:0] regIndex_t;

  // Equal, less and greater after a compare
  typedef logic [2:0] flags_t;

  localparam int FLAG_EQUAL = 0;
  localparam int FLAG_LESS = 1;
  localparam int FLAG_GREATER = 2;

  // Registers with a fixed role
  localparam regIndex_t STACK_POINTER_REG = 'd0;
  localparam regIndex_t FLAG_REG = 'd1;

  typedef enum logic [7:0] {
    movRC     = 8'h01,
    movRR     = 8'h02,
    movRdC    = 8'h03,
    movRdR    = 8'h04,
    movRdRo   = 8'h05,
    movdCR    = 8'h06,
    movdRoR   = 8'h07,
    addRC     = 8'h08,
    addRR     = 8'h09,
    incR      = 8'h0a,
    decR      = 8'h0b,
    mulAddRRC = 8'h0c,
    cmpRR     = 8'h0d,
    cmpRC     = 8'h0e,
    jmpC      = 8'h0f,
    jeC       = 8'h10,
    jneC      = 8'h11,
    pushR     = 8'h12,
    popR      = 8'h13,
    callR     = 8'h14,
    ret       = 8'h15
  } opcode_t;

  typedef enum logic [2:0] {
    fetchPhase,
    decodePhase,
    operandPhase,
    constPhase,
    accessPhase,
    waitPhase,
    commitPhase
  } phase_t;

  typedef enum logic [2:0] {
    aluNone,
    aluAddReg,
    aluAddConst,
    aluInc,
    aluDec,
    aluMulAdd,
    aluCmpReg,
    aluCmpConst
  } aluOp_t;

  // Memory port holder states
  typedef enum logic {
    portIdle,
    portBusy
  } portState_t;

endpackage

// File: source/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
  input  logic            clk,
  input  logic            reset,
  input  cpuPkg::word_t   ramIn,
  input  logic            readAck,
  input  logic            writeAck,
  output cpuPkg::word_t   ramAddress,
  output cpuPkg::word_t   ramOut,
  output logic            readReq,
  output logic            writeReq,
  output cpuPkg::word_t   ipointer,
  output cpuPkg::opcode_t opCode
);
  import cpuPkg::*;

  memAccess_if memBus ();

  // Register file links
  regIndex_t readA;
  regIndex_t readB;
  regIndex_t writeIndex;
  word_t valueA;
  word_t valueB;
  word_t writeValue;
  word_t stackValue;
  word_t stackPointer;
  logic writeEnable;
  logic stackWrite;
  logic flagWrite;
  flags_t flags;

  // Execute links
  aluOp_t aluOp;
  word_t constWord;
  word_t aluResult;
  word_t dataAddress;
  flags_t newFlags;
  logic branchTaken;

  sequencer sequencerInst (
    .clk(clk),
    .reset(reset),
    .mem(memBus.requester),
    .readA(readA),
    .readB(readB),
    .valueA(valueA),
    .valueB(valueB),
    .stackPointer(stackPointer),
    .flags(flags),
    .writeEnable(writeEnable),
    .writeIndex(writeIndex),
    .writeValue(writeValue),
    .stackWrite(stackWrite),
    .stackValue(stackValue),
    .flagWrite(flagWrite),
    .aluOp(aluOp),
    .constWord(constWord),
    .aluResult(aluResult),
    .dataAddress(dataAddress),
    .newFlags(newFlags),
    .branchTaken(branchTaken),
    .ipointer(ipointer),
    .opCode(opCode)
  );

  registerFile registerFileInst (
    .clk(clk),
    .reset(reset),
    .readA(readA),
    .readB(readB),
    .valueA(valueA),
    .valueB(valueB),
    .writeEnable(writeEnable),
    .writeIndex(writeIndex),
    .writeValue(writeValue),
    .stackWrite(stackWrite),
    .stackValue(stackValue),
    .flagWrite(flagWrite),
    .newFlags(newFlags),
    .stackPointer(stackPointer),
    .flags(flags)
  );

  executeUnit executeUnitInst (
    .aluOp(aluOp),
    .opCode(opCode),
    .valueA(valueA),
    .valueB(valueB),
    .constWord(constWord),
    .stackPointer(stackPointer),
    .flags(flags),
    .aluResult(aluResult),
    .dataAddress(dataAddress),
    .newFlags(newFlags),
    .branchTaken(branchTaken)
  );

  // External memory pins
  memoryPort memoryPortInst (
    .clk(clk),
    .reset(reset),
    .mem(memBus.server),
    .ramIn(ramIn),
    .readAck(readAck),
    .writeAck(writeAck),
    .ramAddress(ramAddress),
    .ramOut(ramOut),
    .readReq(readReq),
    .writeReq(writeReq)
  );

endmodule

// File: source/executeUnit.sv
`timescale 1ns/1ps
`include "cpuCore_config.svh"

module executeUnit (
  input  cpuPkg::aluOp_t  aluOp,
  input  cpuPkg::opcode_t opCode,
  input  cpuPkg::word_t   valueA,
  input  cpuPkg::word_t   valueB,
  input  cpuPkg::word_t   constWord,
  input  cpuPkg::word_t   stackPointer,
  input  cpuPkg::flags_t  flags,
  output cpuPkg::word_t   aluResult,
  output cpuPkg::word_t   dataAddress,
  output cpuPkg::flags_t  newFlags,
  output logic            branchTaken
);
  import cpuPkg::*;

  word_t cmpOperand;

  // Arithmetic result, wraps at word width
  always_comb
  begin
    case (aluOp)
      aluAddReg:   aluResult = valueA + valueB;
      aluAddConst: aluResult = valueA + constWord;
      aluInc:      aluResult = valueA + word_t'(1);
      aluDec:      aluResult = valueA - word_t'(1);
      aluMulAdd:   aluResult = valueA + valueB * constWord;
      default:     aluResult = '0;
    endcase
  end

  // Unsigned compare against source or constant
  assign cmpOperand = (aluOp == aluCmpConst) ? constWord : valueB;

  always_comb
  begin
    newFlags = '0;
    newFlags[FLAG_EQUAL] = (valueA == cmpOperand);
    newFlags[FLAG_LESS] = (valueA < cmpOperand);
    newFlags[FLAG_GREATER] = (valueA > cmpOperand);
  end

  // Data address per memory or stack opcode
  always_comb
  begin
    case (opCode)
      movRdC, movdCR: dataAddress = constWord;
      movRdRo:        dataAddress = constWord + valueB;
      movdRoR:        dataAddress = constWord + valueA;
      movRdR:         dataAddress = valueB;
      pushR, callR:   dataAddress = stackPointer;
      // Top of stack sits one step below the pointer
      popR, ret:      dataAddress = stackPointer - word_t'(`STACK_STEP);
      default:        dataAddress = '0;
    endcase
  end

  // Conditional jumps look at the stored equal flag
  always_comb
  begin
    case (opCode)
      jeC:     branchTaken = flags[FLAG_EQUAL];
      jneC:    branchTaken = !flags[FLAG_EQUAL];
      default: branchTaken = 1'b0;
    endcase
  end

endmodule

// File: source/memAccess_if.sv
`timescale 1ns/1ps

interface memAccess_if;
  import cpuPkg::*;

  // Request side, valid while start is high
  logic start;
  logic write;
  word_t address;
  word_t writeData;

  // Completion pulse, readData valid alongside
  logic done;
  word_t readData;

  modport requester (
    output start, write, address, writeData,
    input done, readData
  );

  modport server (
    input start, write, address, writeData,
    output done, readData
  );

endinterface

// File: source/memoryPort.sv
`timescale 1ns/1ps

module memoryPort (
  input  logic          clk,
  input  logic          reset,
  memAccess_if.server   mem,
  input  cpuPkg::word_t ramIn,
  input  logic          readAck,
  input  logic          writeAck,
  output cpuPkg::word_t ramAddress,
  output cpuPkg::word_t ramOut,
  output logic          readReq,
  output logic          writeReq
);
  import cpuPkg::*;

  portState_t state;
  logic acked;

  // Ack only counts for the request that is open
  assign acked = (readReq && readAck) || (writeReq && writeAck);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= portIdle;
      readReq <= 1'b0;
      writeReq <= 1'b0;
      mem.done <= 1'b0;
    end
    else
    begin
      mem.done <= 1'b0;
      case (state)
        portIdle:
        begin
          if (mem.start)
          begin
            readReq <= !mem.write;
            writeReq <= mem.write;
            state <= portBusy;
          end
        end
        portBusy:
        begin
          // Drop request and signal completion together
          if (acked)
          begin
            readReq <= 1'b0;
            writeReq <= 1'b0;
            mem.done <= 1'b1;
            state <= portIdle;
          end
        end
        default: state <= portIdle;
      endcase
    end
  end

  // Address and data held for the whole request
  always_ff @(posedge clk)
  begin
    if (state == portIdle && mem.start)
    begin
      ramAddress <= mem.address;
      ramOut <= mem.writeData;
    end
    if (readReq && readAck)
      mem.readData <= ramIn;
  end

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ps
`include "cpuCore_config.svh"

module registerFile (
  input  logic              clk,
  input  logic              reset,
  input  cpuPkg::regIndex_t readA,
  input  cpuPkg::regIndex_t readB,
  output cpuPkg::word_t     valueA,
  output cpuPkg::word_t     valueB,
  input  logic              writeEnable,
  input  cpuPkg::regIndex_t writeIndex,
  input  cpuPkg::word_t     writeValue,
  input  logic              stackWrite,
  input  cpuPkg::word_t     stackValue,
  input  logic              flagWrite,
  input  cpuPkg::flags_t    newFlags,
  output cpuPkg::word_t     stackPointer,
  output cpuPkg::flags_t    flags
);
  import cpuPkg::*;

  word_t regs [`REG_COUNT];

  // Asynchronous reads
  assign valueA = regs[readA];
  assign valueB = regs[readB];
  assign stackPointer = regs[STACK_POINTER_REG];
  assign flags = regs[FLAG_REG][$bits(flags_t)-1:0];

  // Separate stack and flag paths so popR can update two registers
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end
    else
    begin
      if (writeEnable)
        regs[writeIndex] <= writeValue;
      // Stack pointer update wins over a general write
      if (stackWrite)
        regs[STACK_POINTER_REG] <= stackValue;
      if (flagWrite)
        regs[FLAG_REG] <= word_t'(newFlags);
    end
  end

endmodule

// File: source/sequencer.sv
`timescale 1ns/1ps
`include "cpuCore_config.svh"

module sequencer (
  input  logic              clk,
  input  logic              reset,
  memAccess_if.requester    mem,
  output cpuPkg::regIndex_t readA,
  output cpuPkg::regIndex_t readB,
  input  cpuPkg::word_t     valueA,
  input  cpuPkg::word_t     valueB,
  input  cpuPkg::word_t     stackPointer,
  input  cpuPkg::flags_t    flags,
  output logic              writeEnable,
  output cpuPkg::regIndex_t writeIndex,
  output cpuPkg::word_t     writeValue,
  output logic              stackWrite,
  output cpuPkg::word_t     stackValue,
  output logic              flagWrite,
  output cpuPkg::aluOp_t    aluOp,
  output cpuPkg::word_t     constWord,
  input  cpuPkg::word_t     aluResult,
  input  cpuPkg::word_t     dataAddress,
  input  cpuPkg::flags_t    newFlags,
  input  logic              branchTaken,
  output cpuPkg::word_t     ipointer,
  output cpuPkg::opcode_t   opCode
);
  import cpuPkg::*;

  phase_t phase;
  regIndex_t destIndex;
  regIndex_t srcIndex;
  word_t loadedWord;
  word_t nextPointer;
  logic longOp;
  logic readOp;
  logic writeOp;

  // Opcodes followed by a constant word
  assign longOp = opCode inside {movRC, movRdC, movRdRo, movdCR, movdRoR, addRC,
                                 mulAddRRC, cmpRC, jmpC, jeC, jneC};
  assign readOp = opCode inside {movRdC, movRdR, movRdRo, popR, ret};
  assign writeOp = opCode inside {movdCR, movdRoR, pushR, callR};

  assign readA = destIndex;
  assign readB = srcIndex;
  assign writeIndex = destIndex;

  // Execute function per opcode
  always_comb
  begin
    case (opCode)
      addRR:     aluOp = aluAddReg;
      addRC:     aluOp = aluAddConst;
      incR:      aluOp = aluInc;
      decR:      aluOp = aluDec;
      mulAddRRC: aluOp = aluMulAdd;
      cmpRR:     aluOp = aluCmpReg;
      cmpRC:     aluOp = aluCmpConst;
      default:   aluOp = aluNone;
    endcase
  end

  // One-cycle start in fetch, operand and access phases
  always_comb
  begin
    mem.start = 1'b0;
    mem.write = 1'b0;
    mem.address = ipointer;
    mem.writeData = valueB;
    case (phase)
      fetchPhase: mem.start = 1'b1;
      operandPhase:
      begin
        mem.start = longOp;
        mem.address = ipointer + word_t'(4);
      end
      accessPhase:
      begin
        mem.start = 1'b1;
        mem.write = writeOp;
        mem.address = dataAddress;
        if (opCode == pushR)
          mem.writeData = valueA;
        else if (opCode == callR)
          mem.writeData = ipointer;
      end
      default: ;
    endcase
  end

  // Register, stack and flag commits
  always_comb
  begin
    writeEnable = 1'b0;
    writeValue = aluResult;
    stackWrite = 1'b0;
    stackValue = stackPointer + word_t'(`STACK_STEP);
    flagWrite = 1'b0;
    if (phase == commitPhase)
    begin
      case (opCode)
        movRC:
        begin
          writeEnable = 1'b1;
          writeValue = constWord;
        end
        movRR:
        begin
          writeEnable = 1'b1;
          writeValue = valueB;
        end
        movRdC, movRdR, movRdRo:
        begin
          writeEnable = 1'b1;
          writeValue = loadedWord;
        end
        addRC, addRR, incR, decR, mulAddRRC: writeEnable = 1'b1;
        cmpRR, cmpRC: flagWrite = |newFlags;
        pushR, callR: stackWrite = 1'b1;
        popR:
        begin
          writeEnable = 1'b1;
          writeValue = loadedWord;
          stackWrite = 1'b1;
          stackValue = stackPointer - word_t'(`STACK_STEP);
        end
        ret:
        begin
          stackWrite = 1'b1;
          stackValue = stackPointer - word_t'(`STACK_STEP);
        end
        default: ;
      endcase
    end
  end

  // Jump target, or step past the instruction
  always_comb
  begin
    case (opCode)
      jmpC:     nextPointer = constWord;
      jeC, jneC:
        nextPointer = branchTaken ? constWord : ipointer + word_t'(8);
      callR:    nextPointer = valueA;
      // Resume after the saved call instruction
      ret:      nextPointer = loadedWord + word_t'(4);
      default:  nextPointer = longOp ? ipointer + word_t'(8) : ipointer + word_t'(4);
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      phase <= fetchPhase;
      ipointer <= `RESET_ADDRESS;
      opCode <= opcode_t'('0);
    end
    else
    begin
      case (phase)
        fetchPhase: phase <= decodePhase;
        decodePhase:
        begin
          if (mem.done)
          begin
            opCode <= opcode_t'(mem.readData[7:0]);
            phase <= operandPhase;
          end
        end
        operandPhase:
        begin
          if (longOp)
            phase <= constPhase;
          else if (readOp || writeOp)
            phase <= accessPhase;
          else
            phase <= commitPhase;
        end
        constPhase:
        begin
          if (mem.done)
            phase <= (readOp || writeOp) ? accessPhase : commitPhase;
        end
        accessPhase: phase <= waitPhase;
        waitPhase:
        begin
          if (mem.done)
            phase <= commitPhase;
        end
        commitPhase:
        begin
          ipointer <= nextPointer;
          phase <= fetchPhase;
        end
        default: phase <= fetchPhase;
      endcase
    end
  end

  // Instruction fields, constant and loaded word
  always_ff @(posedge clk)
  begin
    if (phase == decodePhase && mem.done)
    begin
      destIndex <= mem.readData[8 +: `REG_INDEX_WIDTH];
      srcIndex <= mem.readData[16 +: `REG_INDEX_WIDTH];
    end
    if (phase == constPhase && mem.done)
      constWord <= mem.readData;
    if (phase == waitPhase && mem.done)
      loadedWord <= mem.readData;
  end

endmodule

// File: testbench/cpuTb.sv
`timescale 1ns/1ps
`include "cpuCore_config.svh"

module cpuTb;
  import cpuPkg::*;

  localparam int MEM_WORDS = 256;
  localparam int WRITE_TIMEOUT = 3000;
  localparam int FETCH_TIMEOUT = 3;
  localparam int QUIET_CYCLES = 50;
  localparam logic [31:0] SEED = 32'ha35cb8b5;
  localparam word_t SPIN_ADDRESS = 'h124;

  // Data area contents
  localparam word_t DATA0 = 'h0000_1234;
  localparam word_t DATA2 = 'hcafe_0001;
  localparam word_t DATA3 = 'h0000_0007;

  logic clk;
  logic reset;
  word_t ramIn;
  logic readAck;
  logic writeAck;
  word_t ramAddress;
  word_t ramOut;
  logic readReq;
  logic writeReq;
  word_t ipointer;
  opcode_t opCode;

  word_t ram [0:MEM_WORDS-1];
  word_t expAddress [$];
  word_t expData [$];
  int writeCount;

  cpuTop dut_i (
    .clk(clk),
    .reset(reset),
    .ramIn(ramIn),
    .readAck(readAck),
    .writeAck(writeAck),
    .ramAddress(ramAddress),
    .ramOut(ramOut),
    .readReq(readReq),
    .writeReq(writeReq),
    .ipointer(ipointer),
    .opCode(opCode)
  );

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic reportMismatch(input string name, input word_t actual, input word_t expected);
    abortRun($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected));
  endtask

  // Opcode low byte, first register at 11:8, source at 19:16
  function automatic word_t encode(input opcode_t op, input int dest, input int src);
    return {12'h000, regIndex_t'(src), 4'h0, regIndex_t'(dest), op};
  endfunction

  task automatic place(input word_t address, input opcode_t op, input int dest, input int src);
    ram[address[9:2]] = encode(op, dest, src);
  endtask

  // Constant word follows at pointer plus 4
  task automatic placeConst(input word_t address, input opcode_t op, input int dest,
                            input int src, input word_t value);
    ram[address[9:2]] = encode(op, dest, src);
    ram[address[9:2] + 8'd1] = value;
  endtask

  task automatic expectWrite(input word_t address, input word_t data);
    expAddress.push_back(address);
    expData.push_back(data);
  endtask

  task automatic loadProgram();
    for (int i = 0; i < MEM_WORDS; i++)
      ram[i] = 32'hee00_0000 | (i << 2);
    ram['h200 >> 2] = DATA0;
    ram['h204 >> 2] = 'h10;
    ram['h208 >> 2] = DATA2;
    ram['h20c >> 2] = DATA3;
    // Stack base and arithmetic
    placeConst('h00, movRC, 0, 0, 'h300);
    placeConst('h08, movRC, 2, 0, 5);
    placeConst('h10, movRC, 3, 0, 7);
    place('h18, addRR, 2, 3);
    placeConst('h1c, movdCR, 0, 2, 'h280);
    placeConst('h24, addRC, 2, 0, 'h100);
    place('h2c, incR, 3, 0);
    place('h30, decR, 2, 0);
    placeConst('h34, mulAddRRC, 2, 3, 3);
    placeConst('h3c, movRC, 4, 0, 'h200);
    placeConst('h44, movdRoR, 4, 2, 'h84);
    placeConst('h4c, movdRoR, 4, 3, 'h88);
    // Loads, copy and store back
    placeConst('h54, movRdC, 5, 0, 'h200);
    placeConst('h5c, movRdRo, 6, 4, 'h8);
    placeConst('h64, movRC, 7, 0, 'h20c);
    place('h6c, movRdR, 8, 7);
    place('h70, movRR, 9, 5);
    placeConst('h74, movdCR, 0, 9, 'h28c);
    placeConst('h7c, movdCR, 0, 6, 'h290);
    placeConst('h84, movdCR, 0, 8, 'h294);
    // Compare and branch around poison stores
    placeConst('h8c, movRC, 10, 0, 'hbad0_bad0);
    place('h94, cmpRR, 8, 3);
    placeConst('h98, jeC, 0, 0, 'ha8);
    placeConst('ha0, jneC, 0, 0, 'hb0);
    placeConst('ha8, movdCR, 0, 10, 'h2f0);
    placeConst('hb0, cmpRC, 5, 0, DATA0);
    placeConst('hb8, jneC, 0, 0, 'hc8);
    placeConst('hc0, jeC, 0, 0, 'hd0);
    placeConst('hc8, movdCR, 0, 10, 'h2f4);
    placeConst('hd0, movdCR, 0, 1, 'h298);
    placeConst('hd8, jmpC, 0, 0, 'he8);
    placeConst('he0, movdCR, 0, 10, 'h2f8);
    // Stack round trip and a call
    place('he8, pushR, 2, 0);
    place('hec, pushR, 9, 0);
    place('hf0, popR, 11, 0);
    place('hf4, popR, 12, 0);
    placeConst('hf8, movdCR, 0, 11, 'h29c);
    placeConst('h100, movdCR, 0, 12, 'h2a0);
    placeConst('h108, movRC, 13, 0, 'h140);
    place('h110, callR, 13, 0);
    placeConst('h114, movdCR, 0, 14, 'h2a8);
    placeConst('h11c, movdCR, 0, 0, 'h2ac);
    placeConst(SPIN_ADDRESS, jmpC, 0, 0, SPIN_ADDRESS);
    // Subroutine
    placeConst('h140, movRC, 14, 0, 'h5151);
    placeConst('h148, movdCR, 0, 0, 'h2a4);
    place('h150, ret, 0, 0);
  endtask

  task automatic loadExpectations();
    word_t sumReg;
    word_t mulAddReg;
    sumReg = 5 + 7;
    mulAddReg = (sumReg + 'h100 - 1) + (7 + 1) * 3;
    expectWrite('h280, sumReg);
    expectWrite('h284, mulAddReg);
    expectWrite('h288, 7 + 1);
    expectWrite('h28c, DATA0);
    expectWrite('h290, DATA2);
    expectWrite('h294, DATA3);
    // Equal flag alone after the constant compare
    expectWrite('h298, 'h1);
    expectWrite('h300, mulAddReg);
    expectWrite('h304, DATA0);
    expectWrite('h29c, DATA0);
    expectWrite('h2a0, mulAddReg);
    // Return address slot holds the call itself
    expectWrite('h300, 'h110);
    expectWrite('h2a4, 'h300 + `STACK_STEP);
    expectWrite('h2a8, 'h5151);
    expectWrite('h2ac, 'h300);
  endtask

  task automatic checkWrite();
    if (expAddress.size() == 0)
      abortRun($sformatf("unexpected write of %h to %h at %0t", ramOut, ramAddress, $time));
    else
    begin
      assert (ramAddress == expAddress[0])
      else reportMismatch("ramAddress", ramAddress, expAddress[0]);
      assert (ramOut == expData[0])
      else reportMismatch("ramOut", ramOut, expData[0]);
      void'(expAddress.pop_front());
      void'(expData.pop_front());
      writeCount++;
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Memory model, ack after 1 to 4 cycles
  initial
  begin
    int latency;
    bit firstSeen;
    firstSeen = 1'b0;
    forever
    begin
      @(posedge clk);
      #2;
      if (!reset && (readReq || writeReq))
      begin
        if (!firstSeen)
        begin
          assert (readReq) else abortRun("first memory request after reset is a write");
          assert (ramAddress == `RESET_ADDRESS)
          else reportMismatch("ramAddress", ramAddress, `RESET_ADDRESS);
          firstSeen = 1'b1;
        end
        latency = $urandom_range(4, 1);
        repeat (latency - 1)
        begin
          @(posedge clk);
          #2;
        end
        assert (ramAddress < 4 * MEM_WORDS)
        else abortRun($sformatf("memory access outside the model at %h", ramAddress));
        if (readReq)
        begin
          ramIn = ram[ramAddress[9:2]];
          readAck = 1'b1;
        end
        else
        begin
          checkWrite();
          ram[ramAddress[9:2]] = ramOut;
          writeAck = 1'b1;
        end
        @(posedge clk);
        #2;
        readAck = 1'b0;
        writeAck = 1'b0;
      end
    end
  end

  // Pointer steps by 4 or 8 unless a jump lands
  initial
  begin
    word_t lastPointer;
    logic [7:0] committedOp;
    lastPointer = `RESET_ADDRESS;
    forever
    begin
      @(posedge clk);
      #2;
      if (!reset && ipointer != lastPointer)
      begin
        assert ((ipointer - lastPointer) inside {4, 8} ||
                ipointer inside {'hb0, 'hd0, 'he8, 'h140, 'h114})
        else abortRun($sformatf("pointer moved from %h to %h", lastPointer, ipointer));
        // Opcode of the instruction that just committed
        committedOp = ram[lastPointer[9:2]][7:0];
        assert (opCode == committedOp)
        else reportMismatch("opCode", word_t'(opCode), word_t'(committedOp));
        lastPointer = ipointer;
      end
    end
  end

  initial
  begin
    int waitCycles;
    int quietStart;
    void'($urandom(SEED));
    reset = 1'b1;
    ramIn = '0;
    readAck = 1'b0;
    writeAck = 1'b0;
    writeCount = 0;
    loadProgram();
    loadExpectations();
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    // First fetch shortly after release
    waitCycles = 0;
    while (!readReq && waitCycles < FETCH_TIMEOUT)
    begin
      @(posedge clk);
      #2;
      waitCycles++;
    end
    assert (readReq) else abortRun("no fetch request within 3 cycles of reset release");
    waitCycles = 0;
    while (expAddress.size() != 0 && waitCycles < WRITE_TIMEOUT)
    begin
      @(posedge clk);
      #2;
      waitCycles++;
    end
    assert (expAddress.size() == 0)
    else abortRun($sformatf("timed out with %0d expected writes missing", expAddress.size()));
    // Program now spins on its final jump
    quietStart = writeCount;
    repeat (QUIET_CYCLES) @(posedge clk);
    #2;
    assert (writeCount == quietStart) else abortRun("write seen after the last expected store");
    assert (ipointer == SPIN_ADDRESS) else reportMismatch("ipointer", ipointer, SPIN_ADDRESS);
    assert (opCode == jmpC)
    else reportMismatch("opCode", word_t'(opCode), word_t'(jmpC));
    if (dut_i.propertiesInst.failSeen)
      abortRun("memory handshake property failed");
    else
    begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// File: testbench/cpuTop_properties.sv
`timescale 1ns/1ps

module cpuTop_properties (
  input logic          clk,
  input logic          reset,
  input logic          readReq,
  input logic          writeReq,
  input logic          readAck,
  input logic          writeAck,
  input cpuPkg::word_t ramAddress,
  input cpuPkg::word_t ramOut
);

  // Latched once any handshake rule breaks
  bit failSeen = 1'b0;

  // One request direction at a time
  noDualRequest: assert property (@(posedge clk) disable iff (reset)
    !(readReq && writeReq))
  else
  begin
    $error("read and write requests high together");
    failSeen = 1'b1;
  end

  // Read request and address frozen until ack
  readHold: assert property (@(posedge clk) disable iff (reset)
    (readReq && !readAck) |=> (readReq && $stable(ramAddress)))
  else
  begin
    $error("read request changed before its ack");
    failSeen = 1'b1;
  end

  // Write request, address and data frozen until ack
  writeHold: assert property (@(posedge clk) disable iff (reset)
    (writeReq && !writeAck) |=> (writeReq && $stable(ramAddress) && $stable(ramOut)))
  else
  begin
    $error("write request changed before its ack");
    failSeen = 1'b1;
  end

  // Acked request gone one cycle later
  dropAfterAck: assert property (@(posedge clk) disable iff (reset)
    ((readReq && readAck) || (writeReq && writeAck)) |=> (!readReq && !writeReq))
  else
  begin
    $error("request still high after its ack");
    failSeen = 1'b1;
  end

  // Pins quiet while reset is held
  quietInReset: assert property (@(posedge clk) reset |-> (!readReq && !writeReq))
  else
  begin
    $error("memory request raised during reset");
    failSeen = 1'b1;
  end

endmodule

bind cpuTop cpuTop_properties propertiesInst (
  .clk(clk),
  .reset(reset),
  .readReq(readReq),
  .writeReq(writeReq),
  .readAck(readAck),
  .writeAck(writeAck),
  .ramAddress(ramAddress),
  .ramOut(ramOut)
);
